// ==== Makefile ====
# Verilator build for the console core shell

TOP := tb_pce_core_shell
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "TEST OK" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== flist.f ====
hw/pce_shell_pkg.sv
hw/bridge_settings.sv
hw/video_frame_counter.sv
hw/video_output_shaper.sv
hw/pce_core_shell.sv
verif/pce_core_shell_properties.sv
verif/tb_pce_core_shell.sv

// ==== hw/bridge_settings.sv ====
// bridge settings register bank
// decodes host writes into the emulator option bits
// and holds the core reset-delay counter

`timescale 1ns/1ns

module bridge_settings
  import pce_shell_pkg::*;
(
  input  logic         clk_74a,
  input  logic         pll_core_locked,

  // host write strobe, one cycle
  input  logic         bridge_wr,
  input  bridge_addr_t bridge_addr,
  input  bridge_data_t bridge_wr_data,

  output logic         is_sgx,
  output logic         turbo_tap_enable,
  output logic         button6_enable,
  output turbo_speed_t button1_turbo_speed,
  output turbo_speed_t button2_turbo_speed,
  output logic         overscan_enable,
  output logic         extra_sprites_enable,
  output logic         raw_rgb_enable,
  output audio_boost_t master_audio_boost,
  output logic         adpcm_audio_boost,
  output logic         cd_audio_boost,
  output logic         core_reset
);

  logic [RESET_COUNT_W-1:0] reset_count;
  logic                     reset_write;

  ////////////////////////////////////////////////////////////
  // settings registers

  // unmapped addresses fall through untouched
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      is_sgx               <= 1'b0;
      turbo_tap_enable     <= 1'b0;
      button6_enable       <= 1'b0;
      button1_turbo_speed  <= '0;
      button2_turbo_speed  <= '0;
      overscan_enable      <= 1'b0;
      extra_sprites_enable <= 1'b0;
      raw_rgb_enable       <= 1'b0;
      master_audio_boost   <= '0;
      adpcm_audio_boost    <= 1'b0;
      cd_audio_boost       <= 1'b0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        ADDR_SGX:           is_sgx               <= bridge_wr_data[0];
        ADDR_TURBO_TAP:     turbo_tap_enable     <= bridge_wr_data[0];
        ADDR_BUTTON6:       button6_enable       <= bridge_wr_data[0];
        ADDR_B1_TURBO:      button1_turbo_speed  <= bridge_wr_data[1:0];
        ADDR_B2_TURBO:      button2_turbo_speed  <= bridge_wr_data[1:0];
        ADDR_OVERSCAN:      overscan_enable      <= bridge_wr_data[0];
        ADDR_EXTRA_SPRITES: extra_sprites_enable <= bridge_wr_data[0];
        ADDR_RAW_RGB:       raw_rgb_enable       <= bridge_wr_data[0];
        ADDR_MASTER_BOOST:  master_audio_boost   <= bridge_wr_data[1:0];
        ADDR_ADPCM_BOOST:   adpcm_audio_boost    <= bridge_wr_data[0];
        ADDR_CD_BOOST:      cd_audio_boost       <= bridge_wr_data[0];
        default: begin
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // core reset delay

  assign reset_write = bridge_wr && (bridge_addr == ADDR_RESET);

  // any reset write reloads, even mid-count
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_count <= '0;
    end else if (reset_write) begin
      reset_count <= RESET_DELAY_CYCLES;
    end else if (reset_count != '0) begin
      reset_count <= reset_count - 1'b1;
    end
  end

  // high for exactly RESET_DELAY_CYCLES cycles after the write
  assign core_reset = (reset_count != '0);

endmodule

// ==== hw/pce_core_shell.sv ====
// console core shell top level
// bridge settings bank feeding the video frame counter
// and output shaper, all on clk_74a

`timescale 1ns/1ns

module pce_core_shell
  import pce_shell_pkg::*;
(
  input  logic         clk_74a,
  input  logic         pll_core_locked,

  input  logic         bridge_wr,
  input  bridge_addr_t bridge_addr,
  input  bridge_data_t bridge_wr_data,

  // emulator video, held between pixel enables
  input  logic         pix_ce,
  input  logic         h_blank,
  input  logic         v_blank,
  input  logic         core_hs,
  input  logic         core_vs,
  input  logic         border,
  input  dot_div_t     dot_div,
  input  rgb_t         core_rgb,

  output logic         is_sgx,
  output logic         turbo_tap_enable,
  output logic         button6_enable,
  output turbo_speed_t button1_turbo_speed,
  output turbo_speed_t button2_turbo_speed,
  output logic         overscan_enable,
  output logic         extra_sprites_enable,
  output logic         raw_rgb_enable,
  output audio_boost_t master_audio_boost,
  output logic         adpcm_audio_boost,
  output logic         cd_audio_boost,
  output logic         core_reset,

  output logic         video_de,
  output rgb_t         video_rgb,
  output logic         video_hs,
  output logic         video_vs
);

  logic         de_raw;
  logic         expanded_de;
  pixel_count_t pixel_count;
  pixel_count_t pixel_cycle_count;
  line_count_t  line_count;
  logic         line_started;
  logic         frame_started;
  logic         border_active;
  logic         hs_delay_one;
  logic         hs_rise;
  logic         vs_fall;
  logic         vs_rise;
  pixel_count_t last_frame_max;
  logic         de_fall_prev;

  bridge_settings u_settings (
    .clk_74a              (clk_74a),
    .pll_core_locked      (pll_core_locked),
    .bridge_wr            (bridge_wr),
    .bridge_addr          (bridge_addr),
    .bridge_wr_data       (bridge_wr_data),
    .is_sgx               (is_sgx),
    .turbo_tap_enable     (turbo_tap_enable),
    .button6_enable       (button6_enable),
    .button1_turbo_speed  (button1_turbo_speed),
    .button2_turbo_speed  (button2_turbo_speed),
    .overscan_enable      (overscan_enable),
    .extra_sprites_enable (extra_sprites_enable),
    .raw_rgb_enable       (raw_rgb_enable),
    .master_audio_boost   (master_audio_boost),
    .adpcm_audio_boost    (adpcm_audio_boost),
    .cd_audio_boost       (cd_audio_boost),
    .core_reset           (core_reset)
  );

  ////////////////////////////////////////////////////////////
  // video path

  video_frame_counter u_counter (
    .clk_74a           (clk_74a),
    .pll_core_locked   (pll_core_locked),
    .pix_ce            (pix_ce),
    .core_hs           (core_hs),
    .core_vs           (core_vs),
    .border            (border),
    .de_raw            (de_raw),
    .expanded_de       (expanded_de),
    .pixel_count       (pixel_count),
    .pixel_cycle_count (pixel_cycle_count),
    .line_count        (line_count),
    .line_started      (line_started),
    .frame_started     (frame_started),
    .border_active     (border_active),
    .hs_delay_one      (hs_delay_one),
    .hs_rise           (hs_rise),
    .vs_fall           (vs_fall),
    .vs_rise           (vs_rise),
    .last_frame_max    (last_frame_max),
    .de_fall_prev      (de_fall_prev)
  );

  video_output_shaper u_shaper (
    .h_blank           (h_blank),
    .v_blank           (v_blank),
    .core_vs           (core_vs),
    .border_active     (border_active),
    .core_rgb          (core_rgb),
    .dot_div           (dot_div),
    .overscan_enable   (overscan_enable),
    .pixel_count       (pixel_count),
    .pixel_cycle_count (pixel_cycle_count),
    .line_count        (line_count),
    .line_started      (line_started),
    .frame_started     (frame_started),
    .hs_delay_one      (hs_delay_one),
    .hs_rise           (hs_rise),
    .vs_fall           (vs_fall),
    .vs_rise           (vs_rise),
    .last_frame_max    (last_frame_max),
    .de_fall_prev      (de_fall_prev),
    .de_raw            (de_raw),
    .expanded_de       (expanded_de),
    .video_de          (video_de),
    .video_rgb         (video_rgb),
    .video_hs          (video_hs),
    .video_vs          (video_vs)
  );

endmodule

// ==== hw/pce_shell_pkg.sv ====
// shared definitions for the console shell
// bridge address map, field widths, video timing constants
// and the plain vector types used across the design

package pce_shell_pkg;

  ////////////////////////////////////////////////////////////
  // types

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;
  typedef logic [1:0]  turbo_speed_t;
  typedef logic [1:0]  audio_boost_t;
  // red in the top byte, blue in the bottom byte
  typedef logic [23:0] rgb_t;
  typedef logic [9:0]  pixel_count_t;
  typedef logic [8:0]  line_count_t;
  typedef logic [1:0]  dot_div_t;
  typedef logic [1:0]  video_slot_t;

  ////////////////////////////////////////////////////////////
  // bridge address map, one word per setting

  localparam bridge_addr_t ADDR_SGX           = 32'h0000_0004;
  localparam bridge_addr_t ADDR_RESET         = 32'h0000_0050;
  localparam bridge_addr_t ADDR_TURBO_TAP     = 32'h0000_0100;
  localparam bridge_addr_t ADDR_BUTTON6       = 32'h0000_0104;
  localparam bridge_addr_t ADDR_B1_TURBO      = 32'h0000_0108;
  localparam bridge_addr_t ADDR_B2_TURBO      = 32'h0000_010C;
  localparam bridge_addr_t ADDR_OVERSCAN      = 32'h0000_0200;
  localparam bridge_addr_t ADDR_EXTRA_SPRITES = 32'h0000_0204;
  localparam bridge_addr_t ADDR_RAW_RGB       = 32'h0000_0208;
  localparam bridge_addr_t ADDR_MASTER_BOOST  = 32'h0000_0300;
  localparam bridge_addr_t ADDR_ADPCM_BOOST   = 32'h0000_0304;
  localparam bridge_addr_t ADDR_CD_BOOST      = 32'h0000_0308;

  ////////////////////////////////////////////////////////////
  // timing and video constants

  // shortened core reset hold
  localparam int RESET_COUNT_W = 7;
  localparam logic [RESET_COUNT_W-1:0] RESET_DELAY_CYCLES = 7'd64;

  localparam pixel_count_t LINE_WIDTH_352      = 10'd352;
  localparam pixel_count_t LINE_WIDTH_WIDE     = 10'd512;
  localparam line_count_t  LINE_COUNT_FULL     = 9'd240;
  localparam line_count_t  LINE_COUNT_OVERSCAN = 9'd224;

  // border falls a few pixels early, so hold it
  localparam int BORDER_W = 3;
  localparam logic [BORDER_W-1:0] BORDER_HOLD = 3'd4;
  localparam pixel_count_t BORDER_PIXEL_LIMIT = 10'd24;
  localparam pixel_count_t BORDER_CYCLE_LIMIT = 10'd160;

  // keeps hsync clear of the vsync pulse
  localparam int HS_DELAY_W = 3;
  localparam logic [HS_DELAY_W-1:0] HSYNC_DELAY = 3'd6;

  localparam pixel_count_t SLOT_THRESH_HI  = 10'd380;
  localparam pixel_count_t SLOT_THRESH_MID = 10'd330;
  localparam pixel_count_t SLOT_THRESH_LO  = 10'd280;

  localparam dot_div_t DOT_DIV_352 = 2'd1;

  // mode word layout
  localparam int SLOT_BIT_LSB = 14;
  localparam int OVERSCAN_BIT = 13;

endpackage

// ==== hw/video_frame_counter.sv ====
// pixel, pixel-cycle and line counters for the video path
// frame and line start flags, border hold, hsync delay,
// and widest-line tracking for mode classification

`timescale 1ns/1ns

module video_frame_counter
  import pce_shell_pkg::*;
(
  input  logic         clk_74a,
  input  logic         pll_core_locked,
  input  logic         pix_ce,

  input  logic         core_hs,
  input  logic         core_vs,
  input  logic         border,
  input  logic         de_raw,
  input  logic         expanded_de,

  output pixel_count_t pixel_count,
  output pixel_count_t pixel_cycle_count,
  output line_count_t  line_count,
  output logic         line_started,
  output logic         frame_started,
  output logic         border_active,
  output logic         hs_delay_one,
  output logic         hs_rise,
  output logic         vs_fall,
  output logic         vs_rise,
  output pixel_count_t last_frame_max,
  output logic         de_fall_prev
);

  logic                  hs_prev;
  logic                  vs_prev;
  logic                  de_raw_prev;
  logic [BORDER_W-1:0]   border_delay;
  logic [HS_DELAY_W-1:0] hs_delay;
  pixel_count_t          max_pixel_count;

  // shared edge detects against the previous pixel
  assign hs_rise = core_hs && !hs_prev;
  assign vs_rise = core_vs && !vs_prev;
  assign vs_fall = !core_vs && vs_prev;

  assign border_active = (border_delay != '0);
  assign hs_delay_one  = (hs_delay == HS_DELAY_W'(1));

  ////////////////////////////////////////////////////////////
  // previous-pixel state, border hold, hsync delay

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_prev      <= 1'b0;
      vs_prev      <= 1'b0;
      de_raw_prev  <= 1'b0;
      de_fall_prev <= 1'b0;
      border_delay <= '0;
      hs_delay     <= '0;
    end else if (pix_ce) begin
      hs_prev      <= core_hs;
      vs_prev      <= core_vs;
      de_raw_prev  <= de_raw;
      de_fall_prev <= expanded_de;

      if (border) begin
        border_delay <= BORDER_HOLD;
      end else if (border_delay != '0) begin
        border_delay <= border_delay - 1'b1;
      end

      // reload on every rise, output taken at count 1
      if (hs_rise) begin
        hs_delay <= HSYNC_DELAY;
      end else if (hs_delay != '0) begin
        hs_delay <= hs_delay - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // line and frame counting

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      pixel_count       <= '0;
      pixel_cycle_count <= '0;
      line_count        <= '0;
      line_started      <= 1'b0;
      frame_started     <= 1'b0;
    end else if (pix_ce) begin
      // every pixel step, drawn or not; saturates on long lines
      if (pixel_cycle_count != '1) begin
        pixel_cycle_count <= pixel_cycle_count + 1'b1;
      end

      if (hs_rise) begin
        pixel_cycle_count <= '0;
        pixel_count       <= '0;
        line_started      <= 1'b0;
        if (frame_started) begin
          line_count <= line_count + 1'b1;
        end
      end else if (expanded_de || line_started) begin
        // first DE of the line starts the count
        if (pixel_count != '1) begin
          pixel_count <= pixel_count + 1'b1;
        end
        line_started  <= 1'b1;
        frame_started <= 1'b1;
      end

      // frame end takes priority over a coinciding hsync
      if (vs_fall) begin
        line_count    <= '0;
        frame_started <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // widest raw line of the frame

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      max_pixel_count <= '0;
      last_frame_max  <= '0;
    end else if (pix_ce) begin
      if (vs_fall) begin
        max_pixel_count <= '0;
        last_frame_max  <= max_pixel_count;
      end
      // sampled at the raw DE fall
      if (!de_raw && de_raw_prev && (pixel_count > max_pixel_count)) begin
        max_pixel_count <= pixel_count;
      end
    end
  end

endmodule

// ==== hw/video_output_shaper.sv ====
// video output shaping for the scaler
// raw and stretched DE, sync shaping, mode classification
// and the mode word pixel after each line

`timescale 1ns/1ns

module video_output_shaper
  import pce_shell_pkg::*;
(
  input  logic         h_blank,
  input  logic         v_blank,
  input  logic         core_vs,
  input  logic         border_active,
  input  rgb_t         core_rgb,
  input  dot_div_t     dot_div,
  input  logic         overscan_enable,

  input  pixel_count_t pixel_count,
  input  pixel_count_t pixel_cycle_count,
  input  line_count_t  line_count,
  input  logic         line_started,
  input  logic         frame_started,
  input  logic         hs_delay_one,
  input  logic         hs_rise,
  input  logic         vs_fall,
  input  logic         vs_rise,
  input  pixel_count_t last_frame_max,
  input  logic         de_fall_prev,

  output logic         de_raw,
  output logic         expanded_de,
  output logic         video_de,
  output rgb_t         video_rgb,
  output logic         video_hs,
  output logic         video_vs
);

  pixel_count_t expected_width;
  line_count_t  expected_height;
  logic         expanded_h_blank;
  logic         expanded_v_blank;
  logic         expanded_border;
  video_slot_t  video_slot;
  rgb_t         mode_word;

  // 256 and 512 modes share the wide clock, 256 is doubled
  assign expected_width  = (dot_div == DOT_DIV_352) ? LINE_WIDTH_352 : LINE_WIDTH_WIDE;
  assign expected_height = overscan_enable ? LINE_COUNT_OVERSCAN : LINE_COUNT_FULL;

  assign de_raw = !h_blank && !v_blank && !border_active;

  ////////////////////////////////////////////////////////////
  // stretched blanking

  // hblank only once the line is wide enough, never across an hsync
  assign expanded_h_blank = (h_blank && !(line_started && (pixel_count < expected_width)))
                            || hs_rise;

  // vblank only once the frame is tall enough
  assign expanded_v_blank = (v_blank && !(frame_started && (line_count < LINE_COUNT_FULL)))
                            || core_vs || vs_fall;

  // still inside the left border area
  assign expanded_border = border_active && (pixel_count < BORDER_PIXEL_LIMIT)
                           && (pixel_cycle_count < BORDER_CYCLE_LIMIT);

  assign expanded_de = de_raw
                       || (!expanded_h_blank && !expanded_v_blank && !expanded_border
                           && (pixel_count < expected_width)
                           && (line_count < expected_height));

  ////////////////////////////////////////////////////////////
  // mode word

  // 352 wide in slot 2, 320 in slot 1, everything else slot 0
  always_comb begin
    if (last_frame_max > SLOT_THRESH_HI) begin
      video_slot = 2'd0;
    end else if (last_frame_max > SLOT_THRESH_MID) begin
      video_slot = 2'd2;
    end else if (last_frame_max > SLOT_THRESH_LO) begin
      video_slot = 2'd1;
    end else begin
      video_slot = 2'd0;
    end
  end

  always_comb begin
    mode_word = '0;
    mode_word[SLOT_BIT_LSB +: 2] = video_slot;
    mode_word[OVERSCAN_BIT]      = overscan_enable;
  end

  // mode word goes in the first pixel after the stretched DE ends
  assign video_rgb = de_raw ? core_rgb :
                     (de_fall_prev && !expanded_de) ? mode_word : '0;

  assign video_de = expanded_de;
  assign video_hs = hs_delay_one;
  assign video_vs = vs_rise;

endmodule

// ==== verif/pce_core_shell_properties.sv ====
// concurrent checks on the shell outputs
// single-pixel sync pulses and core reset after release

`timescale 1ns/1ns

module pce_core_shell_properties (
  input logic clk_74a,
  input logic pll_core_locked,
  input logic pix_ce,
  input logic video_vs,
  input logic video_hs,
  input logic core_reset
);

  logic vs_last;
  logic hs_last;

  // sync levels of the previous pixel
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      vs_last <= 1'b0;
      hs_last <= 1'b0;
    end else if (pix_ce) begin
      vs_last <= video_vs;
      hs_last <= video_hs;
    end
  end

  vs_single_pixel: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    (pix_ce && vs_last) |-> !video_vs)
    else $error("video_vs high in two consecutive pixels");

  hs_single_pixel: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    (pix_ce && hs_last) |-> !video_hs)
    else $error("video_hs lasted more than one pixel");

  reset_clear_after_release: assert property (@(posedge clk_74a)
    $rose(pll_core_locked) |=> !core_reset)
    else $error("core_reset high right after reset release");

endmodule

bind pce_core_shell pce_core_shell_properties u_props (
  .clk_74a         (clk_74a),
  .pll_core_locked (pll_core_locked),
  .pix_ce          (pix_ce),
  .video_vs        (video_vs),
  .video_hs        (video_hs),
  .core_reset      (core_reset)
);

// ==== verif/tb_pce_core_shell.sv ====
// testbench for the console core shell
// bridge register and reset-delay tests, then short video frames
// checked pixel by pixel against reference functions

`timescale 1ns/1ns

module tb_pce_core_shell
  import pce_shell_pkg::*;
;

  localparam int CYCLE_LIMIT = 20000;
  localparam int HBLANK_LEAD = 8;

  logic clk_74a;
  logic pll_core_locked;
  logic bridge_wr;
  bridge_addr_t bridge_addr;
  bridge_data_t bridge_wr_data;
  logic pix_ce, h_blank, v_blank, core_hs, core_vs, border;
  dot_div_t dot_div;
  rgb_t core_rgb;
  logic is_sgx, turbo_tap_enable, button6_enable, overscan_enable;
  logic extra_sprites_enable, raw_rgb_enable, adpcm_audio_boost, cd_audio_boost;
  turbo_speed_t button1_turbo_speed, button2_turbo_speed;
  audio_boost_t master_audio_boost;
  logic core_reset, video_de, video_hs, video_vs;
  rgb_t video_rgb;

  // expected state
  logic [13:0] exp_settings;
  logic reset_reload;
  int reset_left;
  logic video_check, exp_de, exp_hs, exp_vs;
  rgb_t exp_rgb;
  logic [31:0] lfsr;
  int cycle_count;
  int error_count;
  int line_idx;
  pixel_count_t prev_max;
  // dot clock code of the frame being played
  dot_div_t frame_dot_div;

  pce_core_shell u_dut (.*);

  initial begin
    clk_74a = 1'b0;
    forever #5 clk_74a = ~clk_74a;
  end

  ////////////////////////////////////////////////////////////
  // reference functions

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // {sgx, tap, b6, b1[1:0], b2[1:0], ovs, sprites, raw, master[1:0], adpcm, cd}
  function automatic logic [13:0] settings_after(input logic [13:0] cur,
                                                 input bridge_addr_t a, input bridge_data_t d);
    logic [13:0] s;
    s = cur;
    case (a)
      32'h004: s[13] = d[0];
      32'h100: s[12] = d[0];
      32'h104: s[11] = d[0];
      32'h108: s[10:9] = d[1:0];
      32'h10C: s[8:7] = d[1:0];
      32'h200: s[6] = d[0];
      32'h204: s[5] = d[0];
      32'h208: s[4] = d[0];
      32'h300: s[3:2] = d[1:0];
      32'h304: s[1] = d[0];
      32'h308: s[0] = d[0];
      default: s = cur;
    endcase
    return s;
  endfunction

  function automatic logic [1:0] slot_for_width(input pixel_count_t m);
    if (m > 10'd380) return 2'd0;
    if (m > 10'd330) return 2'd2;
    if (m > 10'd280) return 2'd1;
    return 2'd0;
  endfunction

  function automatic rgb_t mode_word(input logic [1:0] slot, input logic ovs);
    rgb_t m;
    m = '0;
    m[15:14] = slot;
    m[13] = ovs;
    return m;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus helpers

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic bridge_write(input bridge_addr_t a, input bridge_data_t d);
    @(posedge clk_74a);
    bridge_wr <= 1'b1;
    bridge_addr <= a;
    bridge_wr_data <= d;
    reset_reload <= (a == ADDR_RESET);
    @(posedge clk_74a);
    bridge_wr <= 1'b0;
    reset_reload <= 1'b0;
    exp_settings <= settings_after(exp_settings, a, d);
  endtask

  // kind 0 is the vsync line, 1 a blank line, 2 an active line
  task automatic run_line(input int kind, input int n, input int w);
    logic [31:0] r;
    int span;
    logic raw;
    rgb_t pix;
    span = (n > w) ? n : w;
    for (int p = 0; p < HBLANK_LEAD + w + 16; p++) begin
      take_bits(1, r);
      if (r[0]) begin
        @(posedge clk_74a);
        pix_ce <= 1'b0;
      end
      raw = (kind == 2) && (p >= HBLANK_LEAD) && (p < HBLANK_LEAD + n);
      pix = 24'(p * 24'h010307) ^ 24'(line_idx << 8);
      @(posedge clk_74a);
      pix_ce <= 1'b1;
      h_blank <= !raw;
      v_blank <= (kind != 2);
      core_hs <= (p < 2);
      core_vs <= (kind == 0);
      dot_div <= frame_dot_div;
      core_rgb <= pix;
      video_check <= 1'b1;
      exp_de <= (kind == 2) && (p >= HBLANK_LEAD) && (p < HBLANK_LEAD + span);
      exp_hs <= (p == 6);
      exp_vs <= (kind == 0) && (p == 0);
      if (raw) begin
        exp_rgb <= pix;
      end else if ((kind == 2) && (p == HBLANK_LEAD + span)) begin
        exp_rgb <= mode_word(slot_for_width(prev_max), exp_settings[6]);
      end else begin
        exp_rgb <= '0;
      end
    end
    line_idx++;
  endtask

  task automatic stop_on_error();
    error_count++;
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  ////////////////////////////////////////////////////////////
  // expected reset window and comparing process

  always @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_left <= 0;
    end else if (reset_reload) begin
      reset_left <= 64;
    end else if (reset_left > 0) begin
      reset_left <= reset_left - 1;
    end
  end

  always @(negedge clk_74a) begin
    if (pll_core_locked) begin
      assert ({is_sgx, turbo_tap_enable, button6_enable, button1_turbo_speed,
               button2_turbo_speed, overscan_enable, extra_sprites_enable,
               raw_rgb_enable, master_audio_boost, adpcm_audio_boost,
               cd_audio_boost} == exp_settings)
      else begin
        $display("[ERROR] settings: expected %h, got %h", exp_settings,
                 {is_sgx, turbo_tap_enable, button6_enable, button1_turbo_speed,
                  button2_turbo_speed, overscan_enable, extra_sprites_enable,
                  raw_rgb_enable, master_audio_boost, adpcm_audio_boost, cd_audio_boost});
        stop_on_error();
      end
      assert (core_reset == (reset_left != 0))
      else begin
        $display("[ERROR] core_reset: expected %h, got %h", reset_left != 0, core_reset);
        stop_on_error();
      end
      if (pix_ce && video_check) begin
        assert (video_de == exp_de)
        else begin
          $display("[ERROR] video_de: expected %h, got %h", exp_de, video_de);
          stop_on_error();
        end
        assert (video_rgb == exp_rgb)
        else begin
          $display("[ERROR] video_rgb: expected %h, got %h", exp_rgb, video_rgb);
          stop_on_error();
        end
        assert ((video_hs == exp_hs) && (video_vs == exp_vs))
        else begin
          $display("[ERROR] video_hs/video_vs: expected %h/%h, got %h/%h",
                   exp_hs, exp_vs, video_hs, video_vs);
          stop_on_error();
        end
      end
    end
  end

  always @(posedge clk_74a) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: the tests did not finish within the cycle limit");
      stop_on_error();
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    logic [31:0] r;
    logic [31:0] n;
    int w;
    bridge_addr_t mapped [11];
    pixel_count_t cur_max;
    mapped = '{ADDR_SGX, ADDR_TURBO_TAP, ADDR_BUTTON6, ADDR_B1_TURBO, ADDR_B2_TURBO,
                ADDR_OVERSCAN, ADDR_EXTRA_SPRITES, ADDR_RAW_RGB, ADDR_MASTER_BOOST,
                ADDR_ADPCM_BOOST, ADDR_CD_BOOST};
    lfsr = 32'h25ca;
    cycle_count = 0;
    error_count = 0;
    line_idx = 0;
    prev_max = '0;
    frame_dot_div = DOT_DIV_352;
    pll_core_locked = 1'b0;
    bridge_wr = 1'b0;
    bridge_addr = '0;
    bridge_wr_data = '0;
    pix_ce = 1'b0;
    h_blank = 1'b1;
    v_blank = 1'b1;
    core_hs = 1'b0;
    core_vs = 1'b0;
    border = 1'b0;
    dot_div = DOT_DIV_352;
    core_rgb = '0;
    exp_settings = '0;
    reset_reload = 1'b0;
    video_check = 1'b0;
    exp_de = 1'b0;
    exp_hs = 1'b0;
    exp_vs = 1'b0;
    exp_rgb = '0;
    repeat (4) @(posedge clk_74a);
    pll_core_locked <= 1'b1;

    // random settings, twice over the map
    for (int k = 0; k < 22; k++) begin
      take_bits(32, r);
      bridge_write(mapped[k % 11], r);
    end
    // unmapped writes change nothing
    bridge_write(32'h0000_0000, 32'hffff_ffff);
    bridge_write(32'h0000_0110, 32'hffff_ffff);
    bridge_write(32'h0000_030C, 32'hffff_ffff);
    for (int k = 0; k < 4; k++) begin
      take_bits(16, r);
      bridge_write(32'h1000_0000 | r, ~r);
    end

    // reset window, then a reload mid-count
    bridge_write(ADDR_RESET, 32'h1);
    repeat (20) @(posedge clk_74a);
    bridge_write(ADDR_RESET, 32'h1);
    while (core_reset) @(posedge clk_74a);

    // three short frames, dot clock changes with the vsync line
    for (int f = 0; f < 3; f++) begin
      take_bits(1, r);
      frame_dot_div = r[0] ? DOT_DIV_352 : 2'd2;
      w = r[0] ? 352 : 512;
      run_line(0, 0, w);
      run_line(1, 0, w);
      cur_max = '0;
      for (int l = 0; l < 3; l++) begin
        take_bits(8, n);
        n = 200 + (n % 161);
        if (pixel_count_t'(n) > cur_max) begin
          cur_max = pixel_count_t'(n);
        end
        run_line(2, int'(n), w);
      end
      prev_max = cur_max;
    end
    @(posedge clk_74a);
    pix_ce <= 1'b0;
    video_check <= 1'b0;
    repeat (4) @(posedge clk_74a);

    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
